// ==== logic/rv_decode_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// RV64I decode stage types
//////////////////////////////////////////////////////////////////////

package rv_decode_pkg;

  // datapath widths
  localparam int xlen       = 64;
  localparam int ilen       = 32;
  localparam int reg_addr_w = 5;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    opc_load      = 7'h03,
    opc_misc_mem  = 7'h0f,
    opc_op_imm    = 7'h13,
    opc_auipc     = 7'h17,
    opc_op_imm_32 = 7'h1b,
    opc_store     = 7'h23,
    opc_op        = 7'h33,
    opc_lui       = 7'h37,
    opc_op_32     = 7'h3b,
    opc_branch    = 7'h63,
    opc_jalr      = 7'h67,
    opc_jal       = 7'h6f,
    opc_system    = 7'h73
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_or,
    alu_and,
    alu_sll,
    alu_srl,
    alu_sra
  } alu_op_e;

  // branch and jump kind for the branch unit
  typedef enum logic [3:0] {
    bj_none,
    bj_beq,
    bj_bne,
    bj_blt,
    bj_bge,
    bj_bltu,
    bj_bgeu,
    bj_jal,
    bj_jalr
  } bj_op_e;

  typedef enum logic [3:0] {
    mem_none,
    mem_lb,
    mem_lh,
    mem_lw,
    mem_ld,
    mem_lbu,
    mem_lhu,
    mem_lwu,
    mem_sb,
    mem_sh,
    mem_sw,
    mem_sd
  } mem_op_e;

  typedef enum logic [1:0] {
    op1_rs1,
    op1_pc,
    op1_zero
  } op1_sel_e;

  typedef enum logic [1:0] {
    op2_rs2,
    op2_imm,
    op2_four
  } op2_sel_e;

  // immediate layout chosen by the decoder
  typedef enum logic [2:0] {
    imm_none,
    imm_i,
    imm_s,
    imm_b,
    imm_u,
    imm_j
  } imm_fmt_e;

endpackage

// ==== logic/id_latch.sv ====
//////////////////////////////////////////////////////////////////////
// ID pipeline latch
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module id_latch (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           in_valid,
  input  logic [rv_decode_pkg::xlen-1:0] in_pc,
  input  logic [rv_decode_pkg::ilen-1:0] in_inst,
  input  logic                           flush,
  input  logic                           ex_allowin,
  output logic                           allowin,
  output logic                           out_valid,
  output logic [rv_decode_pkg::xlen-1:0] pc,
  output logic [rv_decode_pkg::ilen-1:0] inst
);

  logic stage_valid;

  // empty, or the held instruction leaves this edge
  assign allowin   = !stage_valid || ex_allowin;
  assign out_valid = stage_valid && !flush;

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid <= 1'b0;
    end else if (allowin) begin
      stage_valid <= in_valid;
    end else if (flush) begin
      // held by execute, drop it in place
      stage_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && allowin) begin
      pc   <= in_pc;
      inst <= in_inst;
    end
  end

  a_flush_kills_valid: assert property (
    @(posedge clk) disable iff (rst) flush |-> !out_valid
  );

  // a flushed, stalled instruction must not reappear
  a_flush_empties_stage: assert property (
    @(posedge clk) disable iff (rst) flush && !allowin |=> !out_valid
  );

endmodule

// ==== logic/inst_decoder.sv ====
//////////////////////////////////////////////////////////////////////
// RV64I instruction decoder
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module inst_decoder (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [rv_decode_pkg::ilen-1:0]       inst,
  input  logic                                 valid,
  output logic                                 legal,
  output rv_decode_pkg::alu_op_e               alu_op,
  output logic                                 is_word,
  output rv_decode_pkg::bj_op_e                bj_op,
  output rv_decode_pkg::mem_op_e               mem_op,
  output rv_decode_pkg::op1_sel_e              op1_sel,
  output rv_decode_pkg::op2_sel_e              op2_sel,
  output rv_decode_pkg::imm_fmt_e              imm_fmt,
  output logic [rv_decode_pkg::reg_addr_w-1:0] rs1_addr,
  output logic [rv_decode_pkg::reg_addr_w-1:0] rs2_addr,
  output logic                                 rd_wr_ena,
  output logic [rv_decode_pkg::reg_addr_w-1:0] rd_addr
);
  import rv_decode_pkg::*;

  opcode_e    opcode;
  logic [2:0] func3;
  logic       func6_00;
  logic       func6_10;
  logic       func7_00;
  logic       func7_20;
  logic       use_rs1;
  logic       use_rs2;

  // shared by op, op_imm and their word forms
  function automatic alu_op_e arith_alu(input logic [2:0] f3, input logic alt,
                                        input logic reg_form);
    case (f3)
      3'd0:    arith_alu = (reg_form && alt) ? alu_sub : alu_add;
      3'd1:    arith_alu = alu_sll;
      3'd2:    arith_alu = alu_slt;
      3'd3:    arith_alu = alu_sltu;
      3'd4:    arith_alu = alu_xor;
      3'd5:    arith_alu = alt ? alu_sra : alu_srl;
      3'd6:    arith_alu = alu_or;
      default: arith_alu = alu_and;
    endcase
  endfunction

  assign opcode   = opcode_e'(inst[6:0]);
  assign func3    = inst[14:12];
  assign func6_00 = (inst[31:26] == 6'h00);
  assign func6_10 = (inst[31:26] == 6'h10);
  assign func7_00 = (inst[31:25] == 7'h00);
  assign func7_20 = (inst[31:25] == 7'h20);

  // which encodings exist at all
  always_comb begin
    case (opcode)
      opc_load:      legal = (func3 != 3'd7);
      opc_misc_mem:  legal = (func3 == 3'd0) || (func3 == 3'd1);
      opc_op_imm: begin
        case (func3)
          3'd1:    legal = func6_00;
          3'd5:    legal = func6_00 || func6_10;
          default: legal = 1'b1;
        endcase
      end
      opc_op_imm_32: begin
        case (func3)
          3'd0, 3'd1: legal = 1'b1;
          3'd5:       legal = func6_00 || func6_10;
          default:    legal = 1'b0;
        endcase
      end
      opc_op: begin
        legal = (func3 == 3'd0 || func3 == 3'd5) ? (func7_00 || func7_20) : 1'b1;
      end
      opc_op_32: begin
        case (func3)
          3'd0, 3'd5: legal = func7_00 || func7_20;
          3'd1:       legal = 1'b1;
          default:    legal = 1'b0;
        endcase
      end
      opc_store:     legal = !func3[2];
      opc_branch:    legal = (func3 != 3'd2) && (func3 != 3'd3);
      opc_auipc, opc_lui, opc_jal, opc_jalr: legal = 1'b1;
      // system and anything unknown
      default:       legal = 1'b0;
    endcase
  end

  always_comb begin
    alu_op    = alu_add;
    is_word   = 1'b0;
    bj_op     = bj_none;
    mem_op    = mem_none;
    op1_sel   = op1_rs1;
    op2_sel   = op2_rs2;
    imm_fmt   = imm_none;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    rd_wr_ena = 1'b0;
    if (legal) begin
      case (opcode)
        opc_load: begin
          use_rs1   = 1'b1;
          rd_wr_ena = 1'b1;
          op2_sel   = op2_imm;
          imm_fmt   = imm_i;
          case (func3)
            3'd0:    mem_op = mem_lb;
            3'd1:    mem_op = mem_lh;
            3'd2:    mem_op = mem_lw;
            3'd3:    mem_op = mem_ld;
            3'd4:    mem_op = mem_lbu;
            3'd5:    mem_op = mem_lhu;
            3'd6:    mem_op = mem_lwu;
            default: mem_op = mem_none;
          endcase
        end
        opc_store: begin
          use_rs1 = 1'b1;
          use_rs2 = 1'b1;
          op2_sel = op2_imm;
          imm_fmt = imm_s;
          case (func3[1:0])
            2'd0:    mem_op = mem_sb;
            2'd1:    mem_op = mem_sh;
            2'd2:    mem_op = mem_sw;
            default: mem_op = mem_sd;
          endcase
        end
        opc_op_imm, opc_op_imm_32: begin
          use_rs1   = 1'b1;
          rd_wr_ena = 1'b1;
          op2_sel   = op2_imm;
          imm_fmt   = imm_i;
          is_word   = (opcode == opc_op_imm_32);
          alu_op    = arith_alu(func3, inst[30], 1'b0);
        end
        opc_op, opc_op_32: begin
          use_rs1   = 1'b1;
          use_rs2   = 1'b1;
          rd_wr_ena = 1'b1;
          is_word   = (opcode == opc_op_32);
          alu_op    = arith_alu(func3, inst[30], 1'b1);
        end
        opc_branch: begin
          use_rs1 = 1'b1;
          use_rs2 = 1'b1;
          imm_fmt = imm_b;
          case (func3)
            3'd0:    bj_op = bj_beq;
            3'd1:    bj_op = bj_bne;
            3'd4:    bj_op = bj_blt;
            3'd5:    bj_op = bj_bge;
            3'd6:    bj_op = bj_bltu;
            default: bj_op = bj_bgeu;
          endcase
          // compare kind from func3[2:1]
          case (func3[2:1])
            2'b00:   alu_op = alu_sub;
            2'b10:   alu_op = alu_slt;
            default: alu_op = alu_sltu;
          endcase
        end
        opc_jal, opc_jalr: begin
          // link value pc + 4
          use_rs1   = (opcode == opc_jalr);
          rd_wr_ena = 1'b1;
          op1_sel   = op1_pc;
          op2_sel   = op2_four;
          bj_op     = (opcode == opc_jal) ? bj_jal : bj_jalr;
          imm_fmt   = (opcode == opc_jal) ? imm_j : imm_i;
        end
        opc_lui, opc_auipc: begin
          rd_wr_ena = 1'b1;
          op1_sel   = (opcode == opc_lui) ? op1_zero : op1_pc;
          op2_sel   = op2_imm;
          imm_fmt   = imm_u;
        end
        default: begin
          // fence, an add of rs1 and imm into rd
          use_rs1   = 1'b1;
          rd_wr_ena = 1'b1;
          op2_sel   = op2_imm;
          imm_fmt   = imm_i;
        end
      endcase
    end
  end

  assign rs1_addr = use_rs1 ? inst[19:15] : '0;
  assign rs2_addr = use_rs2 ? inst[24:20] : '0;
  assign rd_addr  = rd_wr_ena ? inst[11:7] : '0;

  a_illegal_is_inert: assert property (
    @(posedge clk) disable iff (rst)
      valid && !legal |-> !rd_wr_ena && (mem_op == mem_none)
  );

endmodule

// ==== logic/imm_gen.sv ====
//////////////////////////////////////////////////////////////////////
// Immediate generator
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module imm_gen (
  input  logic [rv_decode_pkg::ilen-1:0] inst,
  input  rv_decode_pkg::imm_fmt_e        imm_fmt,
  output logic [rv_decode_pkg::xlen-1:0] imm
);
  import rv_decode_pkg::*;

  logic sign;

  // all formats keep the sign in inst[31]
  assign sign = inst[31];

  always_comb begin
    case (imm_fmt)
      imm_i: begin
        imm = {{(xlen-12){sign}}, inst[31:20]};
      end
      imm_s: begin
        imm = {{(xlen-12){sign}}, inst[31:25], inst[11:7]};
      end
      imm_b: begin
        // branch offset, bit 0 always clear
        imm = {{(xlen-13){sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      imm_u: begin
        imm = {{(xlen-32){sign}}, inst[31:12], 12'b0};
      end
      imm_j: begin
        imm = {{(xlen-21){sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

// ==== logic/id_stage.sv ====
//////////////////////////////////////////////////////////////////////
// RV64I instruction decode stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module id_stage (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 if_to_id_valid,
  input  logic [rv_decode_pkg::xlen-1:0]       if_to_id_pc,
  input  logic [rv_decode_pkg::ilen-1:0]       if_to_id_inst,
  input  logic                                 flush,
  input  logic                                 ex_allowin,
  output logic                                 id_allowin,
  output logic                                 id_to_ex_valid,
  output logic [rv_decode_pkg::xlen-1:0]       id_to_ex_pc,
  output logic [rv_decode_pkg::ilen-1:0]       id_to_ex_inst,
  output logic                                 legal,
  output rv_decode_pkg::alu_op_e               alu_op,
  output logic                                 is_word,
  output rv_decode_pkg::bj_op_e                bj_op,
  output rv_decode_pkg::mem_op_e               mem_op,
  output rv_decode_pkg::op1_sel_e              op1_sel,
  output rv_decode_pkg::op2_sel_e              op2_sel,
  output logic [rv_decode_pkg::xlen-1:0]       imm,
  output logic [rv_decode_pkg::reg_addr_w-1:0] rs1_addr,
  output logic [rv_decode_pkg::reg_addr_w-1:0] rs2_addr,
  output logic                                 rd_wr_ena,
  output logic [rv_decode_pkg::reg_addr_w-1:0] rd_addr
);
  import rv_decode_pkg::*;

  imm_fmt_e imm_fmt;

  id_latch u_id_latch (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (if_to_id_valid),
    .in_pc      (if_to_id_pc),
    .in_inst    (if_to_id_inst),
    .flush      (flush),
    .ex_allowin (ex_allowin),
    .allowin    (id_allowin),
    .out_valid  (id_to_ex_valid),
    .pc         (id_to_ex_pc),
    .inst       (id_to_ex_inst)
  );

  inst_decoder u_inst_decoder (
    .clk       (clk),
    .rst       (rst),
    .inst      (id_to_ex_inst),
    .valid     (id_to_ex_valid),
    .legal     (legal),
    .alu_op    (alu_op),
    .is_word   (is_word),
    .bj_op     (bj_op),
    .mem_op    (mem_op),
    .op1_sel   (op1_sel),
    .op2_sel   (op2_sel),
    .imm_fmt   (imm_fmt),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rd_wr_ena (rd_wr_ena),
    .rd_addr   (rd_addr)
  );

  imm_gen u_imm_gen (
    .inst    (id_to_ex_inst),
    .imm_fmt (imm_fmt),
    .imm     (imm)
  );

endmodule

// ==== include/id_tb_checks.svh ====
//////////////////////////////////////////////////////////////////////
// Decode stage compare tasks
//////////////////////////////////////////////////////////////////////

`ifndef ID_TB_CHECKS_SVH
`define ID_TB_CHECKS_SVH

task automatic check_alu(input string what, input rv_decode_pkg::alu_op_e got,
                         input rv_decode_pkg::alu_op_e exp);
  if (got !== exp) begin
    $display("%s: alu_op %s, expected %s", what, got.name(), exp.name());
    fail_now("a decode result did not match its expected value");
  end
endtask

task automatic check_bj(input string what, input rv_decode_pkg::bj_op_e got,
                        input rv_decode_pkg::bj_op_e exp);
  if (got !== exp) begin
    $display("%s: bj_op %s, expected %s", what, got.name(), exp.name());
    fail_now("a decode result did not match its expected value");
  end
endtask

task automatic check_mem(input string what, input rv_decode_pkg::mem_op_e got,
                         input rv_decode_pkg::mem_op_e exp);
  if (got !== exp) begin
    $display("%s: mem_op %s, expected %s", what, got.name(), exp.name());
    fail_now("a decode result did not match its expected value");
  end
endtask

task automatic check_op1(input string what, input rv_decode_pkg::op1_sel_e got,
                         input rv_decode_pkg::op1_sel_e exp);
  if (got !== exp) begin
    $display("%s: op1_sel %s, expected %s", what, got.name(), exp.name());
    fail_now("a decode result did not match its expected value");
  end
endtask

task automatic check_op2(input string what, input rv_decode_pkg::op2_sel_e got,
                         input rv_decode_pkg::op2_sel_e exp);
  if (got !== exp) begin
    $display("%s: op2_sel %s, expected %s", what, got.name(), exp.name());
    fail_now("a decode result did not match its expected value");
  end
endtask

// also used for single-bit flags, zero extended
task automatic check_val64(input string what, input logic [rv_decode_pkg::xlen-1:0] got,
                           input logic [rv_decode_pkg::xlen-1:0] exp);
  if (got !== exp) begin
    $display("%s: got %h, expected %h", what, got, exp);
    fail_now("a decode result did not match its expected value");
  end
endtask

task automatic check_addr5(input string what,
                           input logic [rv_decode_pkg::reg_addr_w-1:0] got,
                           input logic [rv_decode_pkg::reg_addr_w-1:0] exp);
  if (got !== exp) begin
    $display("%s: reg addr %0d, expected %0d", what, got, exp);
    fail_now("a decode result did not match its expected value");
  end
endtask

`endif

// ==== tests/tb_id_stage.sv ====
//////////////////////////////////////////////////////////////////////
// Decode stage testbench
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_id_stage;
  import rv_decode_pkg::*;

  `include "id_tb_checks.svh"

  // about 60 instructions at 3 to 4 cycles each, plus reset and stall, with wide margin
  localparam int max_cycles = 2000;

  logic                  clk;
  logic                  rst;
  logic                  if_to_id_valid;
  logic [xlen-1:0]       if_to_id_pc;
  logic [ilen-1:0]       if_to_id_inst;
  logic                  flush;
  logic                  ex_allowin;
  logic                  id_allowin;
  logic                  id_to_ex_valid;
  logic [xlen-1:0]       id_to_ex_pc;
  logic [ilen-1:0]       id_to_ex_inst;
  logic                  legal;
  alu_op_e               alu_op;
  logic                  is_word;
  bj_op_e                bj_op;
  mem_op_e               mem_op;
  op1_sel_e              op1_sel;
  op2_sel_e              op2_sel;
  logic [xlen-1:0]       imm;
  logic [reg_addr_w-1:0] rs1_addr;
  logic [reg_addr_w-1:0] rs2_addr;
  logic                  rd_wr_ena;
  logic [reg_addr_w-1:0] rd_addr;
  int                    cycle_count = 0;

  // expected results indexed by func3
  alu_op_e f3_alu    [8] = '{alu_add, alu_sll, alu_slt, alu_sltu,
                             alu_xor, alu_srl, alu_or, alu_and};
  mem_op_e load_mem  [7] = '{mem_lb, mem_lh, mem_lw, mem_ld, mem_lbu, mem_lhu, mem_lwu};
  mem_op_e store_mem [4] = '{mem_sb, mem_sh, mem_sw, mem_sd};
  bj_op_e  br_bj     [8] = '{bj_beq, bj_bne, bj_none, bj_none,
                             bj_blt, bj_bge, bj_bltu, bj_bgeu};
  alu_op_e br_alu    [8] = '{alu_sub, alu_sub, alu_add, alu_add,
                             alu_slt, alu_slt, alu_sltu, alu_sltu};

  id_stage u_id_stage (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      fail_now("timeout, the tests did not finish within the cycle limit");
    end
  end

  task automatic fail_now(input string why);
    $display("sim failed");
    $fatal(1, "%s", why);
  endtask

  function automatic logic [ilen-1:0] r_type(input logic [6:0] f7,
      input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3,
      input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [ilen-1:0] i_type(input logic [11:0] imm12,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
      input logic [6:0] opc);
    return {imm12, rs1, f3, rd, opc};
  endfunction

  function automatic logic [ilen-1:0] s_type(input logic [11:0] imm12,
      input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3);
    return {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'h23};
  endfunction

  function automatic logic [ilen-1:0] b_type(input logic [12:0] off,
      input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [ilen-1:0] u_type(input logic [19:0] u20,
      input logic [4:0] rd, input logic [6:0] opc);
    return {u20, rd, opc};
  endfunction

  function automatic logic [ilen-1:0] j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [xlen-1:0] rand_pc();
    logic [xlen-1:0] v;
    v = {$urandom(), $urandom()};
    v[1:0] = 2'b00;
    return v;
  endfunction

  // offer one instruction and return once the stage presents it
  task automatic issue(input logic [xlen-1:0] pc_in, input logic [ilen-1:0] inst_in);
    int waited;
    @(posedge clk);
    #1;
    if_to_id_valid = 1'b1;
    if_to_id_pc    = pc_in;
    if_to_id_inst  = inst_in;
    waited = 0;
    @(negedge clk);
    while (!id_allowin) begin
      waited++;
      if (waited > 20) begin
        fail_now("the decode stage never accepted the offered instruction");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    if_to_id_valid = 1'b0;
    waited = 0;
    @(negedge clk);
    while (!id_to_ex_valid) begin
      waited++;
      if (waited > 20) begin
        fail_now("an accepted instruction never reached execute");
      end
      @(negedge clk);
    end
  endtask

  task automatic expect_decode(input string name, input logic e_legal, input alu_op_e e_alu,
      input logic e_word, input bj_op_e e_bj, input mem_op_e e_mem, input op1_sel_e e_op1,
      input op2_sel_e e_op2, input logic [xlen-1:0] e_imm,
      input logic [reg_addr_w-1:0] e_rs1, input logic [reg_addr_w-1:0] e_rs2,
      input logic e_wr, input logic [reg_addr_w-1:0] e_rd);
    string tag;
    tag = {"FAIL ", name};
    check_val64({tag, " legal"}, 64'(legal), 64'(e_legal));
    check_alu(tag, alu_op, e_alu);
    check_val64({tag, " is_word"}, 64'(is_word), 64'(e_word));
    check_bj(tag, bj_op, e_bj);
    check_mem(tag, mem_op, e_mem);
    check_op1(tag, op1_sel, e_op1);
    check_op2(tag, op2_sel, e_op2);
    check_val64({tag, " imm"}, imm, e_imm);
    check_addr5({tag, " rs1"}, rs1_addr, e_rs1);
    check_addr5({tag, " rs2"}, rs2_addr, e_rs2);
    check_val64({tag, " rd_wr_ena"}, 64'(rd_wr_ena), 64'(e_wr));
    check_addr5({tag, " rd"}, rd_addr, e_rd);
  endtask

  task automatic reset_and_passthrough();
    logic [xlen-1:0] pc_v;
    logic [ilen-1:0] inst_v;
    @(negedge clk);
    check_val64("FAIL reset id_to_ex_valid", 64'(id_to_ex_valid), 64'd0);
    check_val64("FAIL reset id_allowin", 64'(id_allowin), 64'd1);
    pc_v   = rand_pc();
    inst_v = i_type(12'($urandom()), 5'($urandom()), 3'd0, 5'($urandom()), opc_op_imm);
    issue(pc_v, inst_v);
    check_val64("FAIL passthrough pc", id_to_ex_pc, pc_v);
    check_val64("FAIL passthrough inst", 64'(id_to_ex_inst), 64'(inst_v));
  endtask

  task automatic arith_ops();
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] e_rs2;
    logic [2:0]            f3;
    logic                  alt;
    logic [11:0]           imm12;
    logic [xlen-1:0]       e_imm;
    logic [ilen-1:0]       word;
    alu_op_e               e_alu;
    op2_sel_e              e_op2;
    for (int w = 0; w < 2; w++) begin
      for (int form = 0; form < 2; form++) begin
        for (int k = 0; k < 10; k++) begin
          f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
          alt = (k >= 8);
          // word forms have only add/sub, sll and the right shifts
          if (w == 1 && !(f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5)) continue;
          // no subtract immediate
          if (form == 1 && k == 8) continue;
          rs1   = 5'($urandom());
          rs2   = 5'($urandom());
          rd    = 5'($urandom());
          e_alu = !alt ? f3_alu[f3] : ((f3 == 3'd0) ? alu_sub : alu_sra);
          if (form == 0) begin
            word  = r_type(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, (w == 1) ? opc_op_32 : opc_op);
            e_op2 = op2_rs2;
            e_imm = 64'd0;
            e_rs2 = rs2;
          end else begin
            if (f3 == 3'd1 || f3 == 3'd5) begin
              // shift amount, arithmetic flag at imm[10]
              imm12 = {1'b0, alt, 4'b0000, (w == 1) ? 1'b0 : 1'($urandom()), 5'($urandom())};
            end else begin
              imm12 = 12'($urandom());
            end
            word  = i_type(imm12, rs1, f3, rd, (w == 1) ? opc_op_imm_32 : opc_op_imm);
            e_op2 = op2_imm;
            e_imm = {{52{imm12[11]}}, imm12};
            e_rs2 = 5'd0;
          end
          issue(rand_pc(), word);
          expect_decode($sformatf("arith word=%0d imm=%0d f3=%0d alt=%0d", w, form, f3, alt),
                        1'b1, e_alu, 1'(w), bj_none, mem_none, op1_rs1, e_op2, e_imm,
                        rs1, e_rs2, 1'b1, rd);
        end
      end
    end
  endtask

  task automatic memory_and_upper();
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [11:0]           imm12;
    logic [19:0]           u20;
    for (int f = 0; f < 7; f++) begin
      rs1   = 5'($urandom());
      rd    = 5'($urandom());
      imm12 = 12'($urandom());
      issue(rand_pc(), i_type(imm12, rs1, 3'(f), rd, opc_load));
      expect_decode($sformatf("load f3=%0d", f), 1'b1, alu_add, 1'b0, bj_none, load_mem[f],
                    op1_rs1, op2_imm, {{52{imm12[11]}}, imm12}, rs1, 5'd0, 1'b1, rd);
    end
    for (int f = 0; f < 4; f++) begin
      rs1   = 5'($urandom());
      rs2   = 5'($urandom());
      imm12 = 12'($urandom());
      issue(rand_pc(), s_type(imm12, rs2, rs1, 3'(f)));
      expect_decode($sformatf("store f3=%0d", f), 1'b1, alu_add, 1'b0, bj_none, store_mem[f],
                    op1_rs1, op2_imm, {{52{imm12[11]}}, imm12}, rs1, rs2, 1'b0, 5'd0);
    end
    u20 = 20'($urandom());
    rd  = 5'($urandom());
    issue(rand_pc(), u_type(u20, rd, opc_lui));
    expect_decode("lui", 1'b1, alu_add, 1'b0, bj_none, mem_none, op1_zero, op2_imm,
                  {{32{u20[19]}}, u20, 12'h000}, 5'd0, 5'd0, 1'b1, rd);
    u20 = 20'($urandom());
    rd  = 5'($urandom());
    issue(rand_pc(), u_type(u20, rd, opc_auipc));
    expect_decode("auipc", 1'b1, alu_add, 1'b0, bj_none, mem_none, op1_pc, op2_imm,
                  {{32{u20[19]}}, u20, 12'h000}, 5'd0, 5'd0, 1'b1, rd);
  endtask

  task automatic control_transfer();
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [12:0]           boff;
    logic [20:0]           joff;
    logic [11:0]           imm12;
    for (int f = 0; f < 8; f++) begin
      if (f == 2 || f == 3) continue;
      rs1  = 5'($urandom());
      rs2  = 5'($urandom());
      boff = {12'($urandom()), 1'b0};
      issue(rand_pc(), b_type(boff, rs2, rs1, 3'(f)));
      expect_decode($sformatf("branch f3=%0d", f), 1'b1, br_alu[f], 1'b0, br_bj[f], mem_none,
                    op1_rs1, op2_rs2, {{51{boff[12]}}, boff}, rs1, rs2, 1'b0, 5'd0);
    end
    rd   = 5'($urandom());
    joff = {20'($urandom()), 1'b0};
    issue(rand_pc(), j_type(joff, rd));
    expect_decode("jal", 1'b1, alu_add, 1'b0, bj_jal, mem_none, op1_pc, op2_four,
                  {{43{joff[20]}}, joff}, 5'd0, 5'd0, 1'b1, rd);
    rs1   = 5'($urandom());
    rd    = 5'($urandom());
    imm12 = 12'($urandom());
    issue(rand_pc(), i_type(imm12, rs1, 3'd0, rd, opc_jalr));
    expect_decode("jalr", 1'b1, alu_add, 1'b0, bj_jalr, mem_none, op1_pc, op2_four,
                  {{52{imm12[11]}}, imm12}, rs1, 5'd0, 1'b1, rd);
  endtask

  task automatic stall_and_flush();
    logic [xlen-1:0] pc_a;
    logic [ilen-1:0] inst_a;
    logic [11:0]     imm12;
    imm12  = 12'($urandom());
    pc_a   = rand_pc();
    inst_a = i_type(imm12, 5'($urandom()), 3'd4, 5'($urandom()), opc_op_imm);
    @(posedge clk);
    #1;
    ex_allowin = 1'b0;
    issue(pc_a, inst_a);
    // fetch keeps offering another instruction
    @(posedge clk);
    #1;
    if_to_id_valid = 1'b1;
    if_to_id_pc    = rand_pc();
    if_to_id_inst  = ~inst_a;
    repeat (3) begin
      @(negedge clk);
      check_val64("FAIL stall id_allowin", 64'(id_allowin), 64'd0);
      check_val64("FAIL stall id_to_ex_valid", 64'(id_to_ex_valid), 64'd1);
      check_val64("FAIL stall pc", id_to_ex_pc, pc_a);
      check_val64("FAIL stall inst", 64'(id_to_ex_inst), 64'(inst_a));
      check_alu("FAIL stall", alu_op, alu_xor);
      check_val64("FAIL stall imm", imm, {{52{imm12[11]}}, imm12});
    end
    @(posedge clk);
    #1;
    flush          = 1'b1;
    if_to_id_valid = 1'b0;
    @(negedge clk);
    check_val64("FAIL flush id_to_ex_valid", 64'(id_to_ex_valid), 64'd0);
    @(posedge clk);
    #1;
    flush = 1'b0;
    @(negedge clk);
    check_val64("FAIL after flush id_to_ex_valid", 64'(id_to_ex_valid), 64'd0);
    check_val64("FAIL after flush id_allowin", 64'(id_allowin), 64'd1);
    @(posedge clk);
    #1;
    ex_allowin = 1'b1;
  endtask

  task automatic illegal_encodings();
    logic [ilen-1:0] bad [4];
    bad[0] = i_type(12'($urandom()), 5'($urandom()), 3'($urandom()), 5'($urandom()),
                    opc_system);
    // custom-0 opcode
    bad[1] = i_type(12'($urandom()), 5'($urandom()), 3'($urandom()), 5'($urandom()), 7'h0b);
    // multiply, not in the base set
    bad[2] = r_type(7'h01, 5'($urandom()), 5'($urandom()), 3'd0, 5'($urandom()), opc_op);
    bad[3] = i_type(12'($urandom()), 5'($urandom()), 3'd7, 5'($urandom()), opc_load);
    for (int i = 0; i < 4; i++) begin
      issue(rand_pc(), bad[i]);
      expect_decode($sformatf("illegal case %0d", i), 1'b0, alu_add, 1'b0, bj_none, mem_none,
                    op1_rs1, op2_rs2, 64'd0, 5'd0, 5'd0, 1'b0, 5'd0);
    end
  endtask

  initial begin
    void'($urandom(32'h402c6304));
    clk            = 1'b0;
    rst            = 1'b1;
    if_to_id_valid = 1'b0;
    if_to_id_pc    = '0;
    if_to_id_inst  = '0;
    flush          = 1'b0;
    ex_allowin     = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    reset_and_passthrough();
    arith_ops();
    memory_and_upper();
    control_transfer();
    stall_and_flush();
    illegal_encodings();
    $display("sim passed");
    $finish;
  end

endmodule

// ==== id_stage.f ====
+incdir+include
logic/rv_decode_pkg.sv
logic/id_latch.sv
logic/inst_decoder.sv
logic/imm_gen.sv
logic/id_stage.sv
tests/tb_id_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_id_stage -Mdir obj_dir -f id_stage.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_id_stage +verilator+error+limit+100 > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "sim failed" "$log"; then
  echo "simulation reported failure"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if ! grep -qx "sim passed" "$log"; then
  echo "simulation ended without a verdict"
  exit 1
fi

exit 0
